// File: dv/fetch_testdata.txt
// words 0-63: instruction memory image, eight words per line, indexed by pc[7:2]
// then segment count, then one segment per line: min cycles, kind, target, min fetches
03400000 03410101 03420202 03430303 03440404 03450505 03460606 03470707
03480808 03490909 034a0a0a 034b0b0b 034c0c0c 034d0d0d 034e0e0e 034f0f0f
03501010 03511111 03521212 03531313 03541414 03551515 03561616 03571717
03581818 03591919 035a1a1a 035b1b1b 035c1c1c 035d1d1d 035e1e1e 035f1f1f
03602020 03612121 03622222 03632323 03642424 03652525 03662626 03672727
03682828 03692929 036a2a2a 036b2b2b 036c2c2c 036d2d2d 036e2e2e 036f2f2f
03703030 03713131 03723232 03733333 03743434 03753535 03763636 03773737
03783838 03793939 037a3a3a 037b3b3b 037c3c3c 037d3d3d 037e3e3e 037f3f3f
// segment count
0000000c
// kind 0 reset, 1 branch, 2 exception, 3 ertn, 4 decode stall (target is length)
// kind 5 branch held stalled for three cycles
00000014 00000000 1c000000 00000006 // sequential from reset
0000000c 00000004 00000008 00000004 // decode stall window
0000000a 00000001 1c000080 00000004 // branch forward
0000000a 00000002 1c000040 00000004 // exception entry
0000000a 00000003 1c0000a0 00000003 // return to era
0000000a 00000005 1c000020 00000003 // branch after stall
0000000a 00000001 1c000062 00000003 // misaligned branch target
0000000a 00000004 00000006 00000003 // decode stall on misaligned stream
00000006 00000002 1c000010 00000003 // exception back to aligned
00000001 00000001 1c0000f0 00000001 // branch right after one fetch
00000008 00000003 1c000031 00000003 // misaligned era
00000008 00000001 1c000000 00000004 // branch to reset pc

// File: project.f
+incdir+hdl
hdl/fetch_pkg.sv
hdl/pre_if_stage.sv
hdl/if_stage.sv
hdl/fetch_top.sv
dv/fetch_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= fetch_tb
FILELIST  ?= project.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

SOURCES := $(filter-out +%,$(shell cat $(FILELIST)))
HEADERS := $(wildcard hdl/*.svh)
DATA    := dv/fetch_testdata.txt
BIN     := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

# rebuilt only when a source, header or the file list changes
$(BIN): $(SOURCES) $(HEADERS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR) -o V$(TOP)

run: $(BIN) $(DATA)
	@./$(BIN) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "TESTBENCH FAILED" $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -q "TESTBENCH PASSED" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: dv/fetch_tb.sv
`timescale 1ns/1ps
`include "fetch_config.svh"

module fetch_tb;

    localparam int DATA_WORDS = 128;
    localparam int MEM_WORDS  = 64;
    localparam int MAX_SEGS   = 16;

    logic                     clk;
    logic                     reset;
    logic                     ds_allowin;
    fetch_pkg::br_bus_t       br_bus;
    logic                     wb_exc;
    logic                     wb_ertn;
    logic [31:0]              ex_entry;
    logic [31:0]              era;
    logic                     inst_sram_req;
    logic [31:0]              inst_sram_addr;
    logic                     inst_sram_addr_ok;
    logic                     inst_sram_data_ok;
    logic [31:0]              inst_sram_rdata;
    logic                     fs_to_ds_valid;
    fetch_pkg::fs_to_ds_bus_t fs_to_ds_bus;

    logic [31:0] tdata [0:DATA_WORDS-1];
    logic [31:0] mem [0:MEM_WORDS-1];
    int          seg_count;
    int          seg_gap [0:MAX_SEGS-1];
    int          seg_kind [0:MAX_SEGS-1];
    logic [31:0] seg_target [0:MAX_SEGS-1];
    int          seg_fetches [0:MAX_SEGS-1];
    logic        script_ok;

    integer seed;

    // sram model state
    int          accept_wait;
    logic [31:0] resp_addr [$];
    int          resp_due [$];

    int          cycle;
    int          limit;
    int          seg;
    int          seg_cycles;
    int          seg_fetched;
    int          seg_errors_base;
    int          br_stall_left;
    int          decode_stall_left;
    logic        redirect_now;
    logic [31:0] redirect_target;
    logic        done;
    logic        timed_out;
    string       test_name;

    // expected stream
    logic [31:0]              exp_pc;
    logic                     held_prev;
    fetch_pkg::fs_to_ds_bus_t held_bus;

    int tests;
    int checks;
    int errors;

    fetch_top i_fetch_top (
        .clk               (clk),
        .reset             (reset),
        .ds_allowin        (ds_allowin),
        .br_bus            (br_bus),
        .wb_exc            (wb_exc),
        .wb_ertn           (wb_ertn),
        .ex_entry          (ex_entry),
        .era               (era),
        .inst_sram_req     (inst_sram_req),
        .inst_sram_addr    (inst_sram_addr),
        .inst_sram_addr_ok (inst_sram_addr_ok),
        .inst_sram_data_ok (inst_sram_data_ok),
        .inst_sram_rdata   (inst_sram_rdata),
        .fs_to_ds_valid    (fs_to_ds_valid),
        .fs_to_ds_bus      (fs_to_ds_bus)
    );

    always #50 clk = ~clk;

    function automatic string kind_name(input int kind);
        case (kind)
            0: return "reset";
            1: return "branch";
            2: return "exception";
            3: return "ertn";
            4: return "decode_stall";
            5: return "stalled_branch";
            default: return "unknown";
        endcase
    endfunction

    // only a misaligned pc raises a flag in fetch
    function automatic logic [31:0] expected_flags(input logic [31:0] pc);
        fetch_pkg::exc_flags_t flags;
        flags = '0;
        flags[`EXC_FLG_ADEF] = (pc[1:0] != 2'b00);
        return {{(32-`EXC_NUM){1'b0}}, flags};
    endfunction

    function automatic logic [31:0] widen_flags(input fetch_pkg::exc_flags_t flags);
        return {{(32-`EXC_NUM){1'b0}}, flags};
    endfunction

    function automatic logic segment_complete();
        return (seg_cycles >= seg_gap[seg]) && (seg_fetched >= seg_fetches[seg]);
    endfunction

    task automatic check_value(input string what, input logic [31:0] expected,
                               input logic [31:0] actual);
        checks++;
        assert (actual === expected) else begin
            $display("FAILED %s %s: expected %h, actual %h", test_name, what, expected, actual);
            errors++;
        end
    endtask

    task automatic finish_test();
        tests++;
        $display("test %s: %0d fetched in %0d cycles, %0d errors",
                 test_name, seg_fetched, seg_cycles, errors - seg_errors_base);
    endtask

    task automatic start_test(input int index);
        seg             = index;
        seg_cycles      = 0;
        seg_fetched     = 0;
        seg_errors_base = errors;
        test_name       = $sformatf("%s_%0d", kind_name(seg_kind[index]), index);
    endtask

    task automatic load_script();
        for (int i = 0; i < MEM_WORDS; i++) begin
            mem[i] = tdata[i];
        end
        seg_count = tdata[MEM_WORDS];
        script_ok = (seg_count >= 1) && (seg_count <= MAX_SEGS);
        limit     = 0;
        if (script_ok) begin
            for (int i = 0; i < seg_count; i++) begin
                seg_gap[i]     = tdata[MEM_WORDS + 1 + 4*i];
                seg_kind[i]    = tdata[MEM_WORDS + 2 + 4*i];
                seg_target[i]  = tdata[MEM_WORDS + 3 + 4*i];
                seg_fetches[i] = tdata[MEM_WORDS + 4 + 4*i];
                limit          = limit + seg_gap[i] + 40 * seg_fetches[i];
            end
        end
    endtask

    task automatic fire_event(input int index);
        case (seg_kind[index])
            1: begin
                br_bus.br_taken        = 1'b1;
                br_bus.br_taken_cancel = 1'b1;
                br_bus.br_target       = seg_target[index];
                redirect_now           = 1'b1;
            end
            2: begin
                wb_exc       = 1'b1;
                ex_entry     = seg_target[index];
                redirect_now = 1'b1;
                // branch in the same cycle loses to the exception
                br_bus.br_taken  = 1'b1;
                br_bus.br_target = seg_target[index] + 32'h40;
            end
            3: begin
                wb_ertn      = 1'b1;
                era          = seg_target[index];
                redirect_now = 1'b1;
                // branch in the same cycle loses to the return
                br_bus.br_taken  = 1'b1;
                br_bus.br_target = seg_target[index] + 32'h40;
            end
            4: decode_stall_left = seg_target[index];
            5: begin
                // target unresolved for three cycles
                br_stall_left          = 3;
                br_bus.br_taken        = 1'b1;
                br_bus.br_taken_cancel = 1'b1;
                br_bus.br_stall        = 1'b1;
                br_bus.br_target       = seg_target[index];
            end
            default: ;
        endcase
        redirect_target = seg_target[index];
        if (seg_kind[index] != 5) begin
            finish_test();
            start_test(index);
        end
    endtask

    task automatic drive_inputs();
        logic [31:0] addr;
        br_bus       = '0;
        wb_exc       = 1'b0;
        wb_ertn      = 1'b0;
        redirect_now = 1'b0;
        if (br_stall_left > 0) begin
            br_stall_left--;
            br_bus.br_taken        = 1'b1;
            br_bus.br_taken_cancel = 1'b1;
            br_bus.br_stall        = (br_stall_left != 0);
            br_bus.br_target       = seg_target[seg + 1];
            if (br_stall_left == 0) begin
                finish_test();
                start_test(seg + 1);
                redirect_now    = 1'b1;
                redirect_target = seg_target[seg];
            end
        end else if (segment_complete()) begin
            if (seg == seg_count - 1) begin
                done = 1'b1;
            end else begin
                fire_event(seg + 1);
            end
        end

        if (decode_stall_left > 0) begin
            ds_allowin = 1'b0;
            decode_stall_left--;
        end else begin
            ds_allowin = ({$random(seed)} % 8) != 0;
        end

        inst_sram_addr_ok = (accept_wait == 0);
        if (resp_due.size() > 0 && resp_due[0] <= cycle) begin
            addr = resp_addr.pop_front();
            void'(resp_due.pop_front());
            inst_sram_data_ok = 1'b1;
            inst_sram_rdata   = mem[addr[7:2]];
        end else begin
            inst_sram_data_ok = 1'b0;
            inst_sram_rdata   = $random(seed);
        end
    endtask

    task automatic sample_outputs();
        // request timing right after reset
        if (cycle == 0) begin
            check_value("req in reset cycle", 32'd0, {31'd0, inst_sram_req});
            check_value("valid in reset cycle", 32'd0, {31'd0, fs_to_ds_valid});
        end else if (cycle == 1) begin
            check_value("first req", 32'd1, {31'd0, inst_sram_req});
            check_value("first addr", `FETCH_RESET_PC, inst_sram_addr);
        end

        if (fs_to_ds_valid && ds_allowin) begin
            check_value("pc", exp_pc, fs_to_ds_bus.pc);
            check_value("inst", mem[exp_pc[7:2]], fs_to_ds_bus.inst);
            check_value("exc", expected_flags(exp_pc), widen_flags(fs_to_ds_bus.exc));
            exp_pc = exp_pc + 32'd4;
            seg_fetched++;
        end
        // bus must hold while decode stalls
        if (held_prev && !redirect_now) begin
            check_value("held valid", 32'd1, {31'd0, fs_to_ds_valid});
        end
        if (held_prev && fs_to_ds_valid) begin
            check_value("held pc", held_bus.pc, fs_to_ds_bus.pc);
            check_value("held inst", held_bus.inst, fs_to_ds_bus.inst);
            check_value("held exc", widen_flags(held_bus.exc), widen_flags(fs_to_ds_bus.exc));
        end
        held_prev = fs_to_ds_valid && !ds_allowin;
        held_bus  = fs_to_ds_bus;
        if (redirect_now) begin
            check_value("valid in redirect cycle", 32'd0, {31'd0, fs_to_ds_valid});
            exp_pc = redirect_target;
        end

        if (inst_sram_req && inst_sram_addr_ok) begin
            resp_addr.push_back(inst_sram_addr);
            resp_due.push_back(cycle + 1 + ({$random(seed)} % 3));
            accept_wait = {$random(seed)} % 3;
        end else if (inst_sram_req && accept_wait > 0) begin
            accept_wait--;
        end
        seg_cycles++;
    endtask

    initial begin
        clk               = 1'b0;
        reset             = 1'b1;
        ds_allowin        = 1'b0;
        br_bus            = '0;
        wb_exc            = 1'b0;
        wb_ertn           = 1'b0;
        ex_entry          = 32'd0;
        era               = 32'd0;
        inst_sram_addr_ok = 1'b0;
        inst_sram_data_ok = 1'b0;
        inst_sram_rdata   = 32'd0;
        seed              = 32'hc9b3_c6c7;
        accept_wait       = 0;
        cycle             = 0;
        br_stall_left     = 0;
        decode_stall_left = 0;
        redirect_now      = 1'b0;
        redirect_target   = 32'd0;
        done              = 1'b0;
        timed_out         = 1'b0;
        held_prev         = 1'b0;
        held_bus          = '0;
        tests             = 0;
        checks            = 0;
        errors            = 0;
        test_name         = "none";

        $readmemh("dv/fetch_testdata.txt", tdata);
        load_script();

        repeat (2) @(posedge clk);
        #1;
        reset = 1'b0;

        if (!script_ok) begin
            $display("test data unusable, segment count %0d", seg_count);
        end else begin
            start_test(0);
            exp_pc = `FETCH_RESET_PC;
            while (!done && !timed_out) begin
                drive_inputs();
                @(negedge clk);
                sample_outputs();
                @(posedge clk);
                #1;
                cycle++;
                if (cycle >= limit) begin
                    timed_out = 1'b1;
                end
            end
            if (timed_out) begin
                $display("timeout: run stopped after %0d cycles in test %s", cycle, test_name);
            end else begin
                finish_test();
            end
        end

        $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
        if (script_ok && !timed_out && errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

// File: hdl/fetch_top.sv
`timescale 1ns/1ps

module fetch_top (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     ds_allowin,
    input  fetch_pkg::br_bus_t       br_bus,
    input  logic                     wb_exc,
    input  logic                     wb_ertn,
    input  logic [31:0]              ex_entry,
    input  logic [31:0]              era,
    output logic                     inst_sram_req,
    output logic [31:0]              inst_sram_addr,
    input  logic                     inst_sram_addr_ok,
    input  logic                     inst_sram_data_ok,
    input  logic [31:0]              inst_sram_rdata,
    output logic                     fs_to_ds_valid,
    output fetch_pkg::fs_to_ds_bus_t fs_to_ds_bus
);

    logic                      fs_allowin;
    logic                      fs_block;
    logic                      pfs_to_fs_valid;
    fetch_pkg::pfs_to_fs_bus_t pfs_to_fs_bus;

    pre_if_stage i_pre_if_stage (
        .clk               (clk),
        .reset             (reset),
        .br_bus            (br_bus),
        .wb_exc            (wb_exc),
        .wb_ertn           (wb_ertn),
        .ex_entry          (ex_entry),
        .era               (era),
        .fs_allowin        (fs_allowin),
        .fs_block          (fs_block),
        .pfs_to_fs_valid   (pfs_to_fs_valid),
        .pfs_to_fs_bus     (pfs_to_fs_bus),
        .inst_sram_req     (inst_sram_req),
        .inst_sram_addr    (inst_sram_addr),
        .inst_sram_addr_ok (inst_sram_addr_ok)
    );

    if_stage i_if_stage (
        .clk               (clk),
        .reset             (reset),
        .ds_allowin        (ds_allowin),
        .br_bus            (br_bus),
        .wb_exc            (wb_exc),
        .wb_ertn           (wb_ertn),
        .pfs_to_fs_valid   (pfs_to_fs_valid),
        .pfs_to_fs_bus     (pfs_to_fs_bus),
        .fs_allowin        (fs_allowin),
        .fs_block          (fs_block),
        .inst_sram_data_ok (inst_sram_data_ok),
        .inst_sram_rdata   (inst_sram_rdata),
        .fs_to_ds_valid    (fs_to_ds_valid),
        .fs_to_ds_bus      (fs_to_ds_bus)
    );

endmodule

// File: hdl/if_stage.sv
`timescale 1ns/1ps
`include "fetch_config.svh"

module if_stage (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      ds_allowin,
    input  fetch_pkg::br_bus_t        br_bus,
    input  logic                      wb_exc,
    input  logic                      wb_ertn,
    input  logic                      pfs_to_fs_valid,
    input  fetch_pkg::pfs_to_fs_bus_t pfs_to_fs_bus,
    output logic                      fs_allowin,
    output logic                      fs_block,
    input  logic                      inst_sram_data_ok,
    input  logic [31:0]               inst_sram_rdata,
    output logic                      fs_to_ds_valid,
    output fetch_pkg::fs_to_ds_bus_t  fs_to_ds_bus
);

    logic        fs_valid;
    logic        fs_ready_go;
    logic [31:0] fs_pc;

    logic        fs_inst_valid;
    logic [31:0] fs_inst_buff;
    logic        buff_load;

    logic        fs_cancel;
    logic        fs_outstanding;
    logic        discard;
    logic        discard_next;

    fetch_pkg::exc_flags_t fs_exc;

    assign fs_cancel = wb_exc || wb_ertn || (br_bus.br_taken && !br_bus.br_stall);

    // response still on its way for the current pc
    assign fs_outstanding = fs_valid && !fs_inst_valid;

    assign fs_ready_go    = fs_valid && (fs_inst_valid || inst_sram_data_ok);
    assign fs_allowin     = !fs_valid || (fs_ready_go && ds_allowin);
    assign fs_to_ds_valid = fs_ready_go && !fs_cancel;

    // a stale response in flight also blocks new requests
    assign fs_block = (!fs_valid || fs_inst_valid) && !discard;

    always_ff @(posedge clk) begin
        if (reset) begin
            fs_valid <= 1'b0;
        end else if (fs_cancel) begin
            fs_valid <= 1'b0;
        end else if (fs_allowin) begin
            fs_valid <= pfs_to_fs_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (pfs_to_fs_valid && fs_allowin) begin
            fs_pc <= pfs_to_fs_bus.pc;
        end
    end

    // word arrived but decode is stalled
    assign buff_load = fs_outstanding && inst_sram_data_ok && !ds_allowin && !fs_cancel;

    always_ff @(posedge clk) begin
        if (reset) begin
            fs_inst_valid <= 1'b0;
        end else if (fs_cancel) begin
            fs_inst_valid <= 1'b0;
        end else if (buff_load) begin
            fs_inst_valid <= 1'b1;
        end else if (ds_allowin) begin
            fs_inst_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (buff_load) begin
            fs_inst_buff <= inst_sram_rdata;
        end
    end

    // swallow the next data_ok when a cancel leaves a response outstanding
    always_comb begin
        if (fs_cancel) begin
            discard_next = (discard || fs_outstanding) && !inst_sram_data_ok;
        end else begin
            discard_next = discard && !inst_sram_data_ok;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            discard <= 1'b0;
        end else begin
            discard <= discard_next;
        end
    end

    // only address error is raised in fetch
    always_comb begin
        fs_exc = '0;
        fs_exc[`EXC_FLG_ADEF] = |fs_pc[1:0];
    end

    assign fs_to_ds_bus.exc  = fs_exc;
    assign fs_to_ds_bus.inst = fs_inst_valid ? fs_inst_buff : inst_sram_rdata;
    assign fs_to_ds_bus.pc   = fs_pc;

endmodule

// File: hdl/pre_if_stage.sv
`timescale 1ns/1ps
`include "fetch_config.svh"

module pre_if_stage (
    input  logic                     clk,
    input  logic                     reset,
    input  fetch_pkg::br_bus_t       br_bus,
    input  logic                     wb_exc,
    input  logic                     wb_ertn,
    input  logic [31:0]              ex_entry,
    input  logic [31:0]              era,
    input  logic                     fs_allowin,
    input  logic                     fs_block,
    output logic                     pfs_to_fs_valid,
    output fetch_pkg::pfs_to_fs_bus_t pfs_to_fs_bus,
    output logic                     inst_sram_req,
    output logic [31:0]              inst_sram_addr,
    input  logic                     inst_sram_addr_ok
);

    logic        pfs_live;
    logic [31:0] pfs_pc;
    logic [31:0] seq_pc;

    logic        br_redirect;
    logic        br_wait;
    logic        redirect;
    logic [31:0] redirect_pc;

    // pending redirect, applied to the next request
    logic        redir_valid;
    logic [31:0] redir_pc;

    logic [31:0] req_pc;
    logic        can_issue;
    logic        req_accept;

    assign br_redirect = br_bus.br_taken && !br_bus.br_stall;
    // taken branch with target still unknown, hold off fetching
    assign br_wait     = br_bus.br_taken && br_bus.br_stall;
    assign redirect    = wb_exc || wb_ertn || br_redirect;

    // fixed priority: exception entry, return address, branch target
    always_comb begin
        if (wb_exc) begin
            redirect_pc = ex_entry;
        end else if (wb_ertn) begin
            redirect_pc = era;
        end else begin
            redirect_pc = br_bus.br_target;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            pfs_live <= 1'b0;
        end else begin
            pfs_live <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            redir_valid <= 1'b0;
        end else if (redirect) begin
            redir_valid <= 1'b1;
        end else if (req_accept) begin
            redir_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (redirect) begin
            redir_pc <= redirect_pc;
        end
    end

    // address of the next request
    assign req_pc = redir_valid ? redir_pc : pfs_pc;
    assign seq_pc = req_pc + 32'd4;

    always_ff @(posedge clk) begin
        if (reset) begin
            pfs_pc <= `FETCH_RESET_PC;
        end else if (req_accept) begin
            pfs_pc <= seq_pc;
        end
    end

    // only fetch when fetch stage has no response of its own pending
    // and can take the accepted address in this cycle
    assign can_issue = fs_block && fs_allowin;

    // no request in a redirect cycle, the address would be stale
    assign inst_sram_req  = pfs_live && can_issue && !redirect && !br_wait;
    assign inst_sram_addr = req_pc;
    assign req_accept     = inst_sram_req && inst_sram_addr_ok;

    assign pfs_to_fs_valid  = req_accept;
    assign pfs_to_fs_bus.pc = req_pc;

endmodule

// File: hdl/fetch_pkg.sv
`include "fetch_config.svh"

package fetch_pkg;

    // one bit per exception kind, see fetch_config.svh for positions
    typedef logic [`EXC_NUM-1:0] exc_flags_t;

    // redirect from execute
    typedef struct packed {
        logic        br_taken;
        logic        br_taken_cancel;
        // target not yet resolved
        logic        br_stall;
        logic [31:0] br_target;
    } br_bus_t;

    // pre-fetch to fetch
    typedef struct packed {
        logic [31:0] pc;
    } pfs_to_fs_bus_t;

    // fetch to decode
    typedef struct packed {
        exc_flags_t  exc;
        logic [31:0] inst;
        logic [31:0] pc;
    } fs_to_ds_bus_t;

endpackage

// File: hdl/fetch_config.svh
`ifndef FETCH_CONFIG_SVH
`define FETCH_CONFIG_SVH

// first fetch address after reset
`define FETCH_RESET_PC 32'h1c00_0000

// exception flag vector
`define EXC_NUM 6

// flag positions inside the vector
`define EXC_FLG_ADEF 0
`define EXC_FLG_SYS  1
`define EXC_FLG_ALE  2
`define EXC_FLG_BRK  3
`define EXC_FLG_INE  4
`define EXC_FLG_INT  5

`endif
